// ==== verification/icb_bus_patterns.hex ====
// columns: op _ addr _ wdata _ wmask _ enables _ expected target (8 = default)
// op 1 is a read, op 0 is a write.
1_10000010_00000000_f_ff_0
0_10001abc_11223344_f_ff_1
1_10002ffc_00000000_f_ff_2
1_10003000_00000000_f_ff_3
0_10004004_deadbeef_3_ff_4
1_10005100_00000000_f_ff_5
1_10006200_00000000_f_ff_6
1_2000fff0_00000000_f_ff_7
1_20001234_00000000_f_ff_7
0_20000008_cafef00d_c_ff_7
1_30000000_00000000_f_ff_8
1_10007000_00000000_f_ff_8
1_10000020_00000000_f_ff_0
1_10000024_00000000_f_ff_0
1_10003010_00000000_f_ff_3
1_10003020_00000000_f_f7_8
1_10002020_00000000_f_f7_2
1_20000040_00000000_f_7f_8
0_1000603c_55aa55aa_5_7f_6
1_00000000_00000000_f_7f_8

// ==== sources.f ====
src/icb_bus_pkg.sv
src/icb_cmd_buffer.sv
src/icb_addr_decode.sv
src/icb_splitter.sv
src/icb_bus_1to8.sv
verification/icb_bus_props.sv
verification/icb_bus_tb.sv

// ==== Makefile ====
# Verilator build and run for the bus router testbench.

SIM     ?= verilator
TOP     ?= icb_bus_tb
LOG     ?= sim.log
OBJ_DIR ?= obj_dir
FLIST   ?= sources.f

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) --binary --assert -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Simulation finished: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/icb_bus_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module icb_bus_tb;

  localparam int NT = icb_bus_pkg::TGT_NUM;
  localparam int MAX_PAT = 64;

  logic                    clk;
  logic                    rst_n = 1'b0;
  logic [NT-1:0]           tgt_en = '1;
  logic                    cmd_valid = 1'b0;
  logic                    cmd_ready;
  icb_bus_pkg::icb_cmd_t   cmd = '0;
  logic                    rsp_valid;
  logic                    rsp_ready = 1'b0;
  icb_bus_pkg::icb_rsp_t   rsp;
  logic [NT-1:0]           tgt_cmd_valid;
  logic [NT-1:0]           tgt_cmd_ready = '0;
  icb_bus_pkg::icb_cmd_t   tgt_cmd [NT];
  logic [NT-1:0]           tgt_rsp_valid = '0;
  logic [NT-1:0]           tgt_rsp_ready;
  icb_bus_pkg::icb_rsp_t   tgt_rsp [NT];

  // pattern word: op, addr, wdata, wmask, enables, expected target.
  logic [83:0]             pat [MAX_PAT];
  int                      n_pat = 0;
  logic [3:0]              cur_tgt = 4'd0;
  int                      acc_cnt = 0;
  int                      rsp_cnt = 0;
  int                      err_cnt = 0;
  int                      chk_cnt = 0;
  logic [31:0]             lfsr_q = 32'he5151778;

  icb_bus_pkg::icb_rsp_t   exp_rsp_q [$];
  int                      route_tgt_q [$];
  icb_bus_pkg::icb_cmd_t   route_cmd_q [$];

  // target model state, owned by the posedge monitor.
  icb_bus_pkg::icb_rsp_t   pend [NT][2];
  int                      pend_cnt [NT];
  int                      delay [NT];
  logic [NT-1:0]           shown;
  logic [NT-1:0]           ready_nxt;
  logic                    rsp_ready_nxt;

  icb_bus_1to8 dut_i (
    .clk             (clk),
    .i_rst_n         (rst_n),
    .i_tgt_en        (tgt_en),
    .i_cmd_valid     (cmd_valid),
    .o_cmd_ready     (cmd_ready),
    .i_cmd           (cmd),
    .o_rsp_valid     (rsp_valid),
    .i_rsp_ready     (rsp_ready),
    .o_rsp           (rsp),
    .o_tgt_cmd_valid (tgt_cmd_valid),
    .i_tgt_cmd_ready (tgt_cmd_ready),
    .o_tgt_cmd       (tgt_cmd),
    .i_tgt_rsp_valid (tgt_rsp_valid),
    .o_tgt_rsp_ready (tgt_rsp_ready),
    .i_tgt_rsp       (tgt_rsp)
  );

  initial begin
    for (int t = 0; t < NT; t++) begin
      tgt_rsp[t] = '0;
    end
  end

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // fibonacci lfsr with taps 32, 22, 2 and 1.
  function automatic logic rand_bit();
    lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
    return lfsr_q[0];
  endfunction

  function automatic icb_bus_pkg::icb_rsp_t expect_rsp(input logic [3:0] tgt,
                                                       input logic [31:0] addr);
    icb_bus_pkg::icb_rsp_t r;
    if (tgt == 4'd8) begin
      r.err   = 1'b1; // unmapped commands come back as errors.
      r.rdata = '0;
    end else begin
      r.err   = 1'b0;
      r.rdata = addr ^ ({28'd0, tgt} * 32'h0101_0101);
    end
    return r;
  endfunction

  always @(posedge clk) begin
    if (!rst_n) begin
      shown         = '0;
      ready_nxt     = '0;
      rsp_ready_nxt = 1'b0;
      for (int t = 0; t < NT; t++) begin
        pend[t][0]  = '0;
        pend[t][1]  = '0;
        pend_cnt[t] = 0;
        delay[t]    = 0;
      end
    end else begin
      chk_cnt++;
      if (acc_cnt == 0 && (rsp_valid || tgt_cmd_valid != '0)) begin
        $display("ERROR: outputs became active before the first command was sent.");
        err_cnt++;
      end
      if (cmd_valid && cmd_ready) begin
        exp_rsp_q.push_back(expect_rsp(cur_tgt, cmd.addr));
        if (cur_tgt != 4'd8) begin
          route_tgt_q.push_back(int'(cur_tgt));
          route_cmd_q.push_back(cmd);
        end
        acc_cnt++;
      end
      for (int t = 0; t < NT; t++) begin
        if (tgt_rsp_valid[t] && tgt_rsp_ready[t]) begin
          pend[t][0]  = pend[t][1];
          pend_cnt[t] = pend_cnt[t] - 1;
          shown[t]    = 1'b0;
          delay[t]    = int'({rand_bit(), rand_bit()});
        end
        if (tgt_cmd_valid[t] && tgt_cmd_ready[t]) begin
          chk_cnt++;
          if (route_tgt_q.size() == 0 || pend_cnt[t] >= 2) begin
            $display("ERROR: target %0d received a command that was not meant for it.", t);
            err_cnt++;
          end else begin
            if (route_tgt_q[0] != t || route_cmd_q[0] != tgt_cmd[t]) begin
              $display("ERROR route: expected target %0d cmd %h, actual target %0d cmd %h",
                       route_tgt_q[0], route_cmd_q[0], t, tgt_cmd[t]);
              err_cnt++;
            end
            void'(route_tgt_q.pop_front());
            void'(route_cmd_q.pop_front());
            pend[t][pend_cnt[t]].err   = 1'b0;
            pend[t][pend_cnt[t]].rdata = tgt_cmd[t].addr ^ (32'(t) * 32'h0101_0101);
            pend_cnt[t] = pend_cnt[t] + 1;
          end
        end
        if (!shown[t] && pend_cnt[t] > 0) begin
          if (delay[t] == 0) shown[t] = 1'b1;
          else delay[t] = delay[t] - 1;
        end
        ready_nxt[t] = ({rand_bit(), rand_bit()} != 2'b00);
      end
      if (rsp_valid && rsp_ready) begin
        chk_cnt++;
        if (exp_rsp_q.size() == 0) begin
          $display("ERROR: a response arrived with no command waiting for one.");
          err_cnt++;
        end else begin
          if (rsp != exp_rsp_q[0]) begin
            $display("ERROR rsp %0d: expected %h, actual %h", rsp_cnt, exp_rsp_q[0], rsp);
            err_cnt++;
          end
          void'(exp_rsp_q.pop_front());
        end
        rsp_cnt++;
      end
      rsp_ready_nxt = rand_bit() | rand_bit();
    end
  end

  // target side inputs change only on the falling edge.
  always @(negedge clk) begin
    tgt_cmd_ready = ready_nxt;
    tgt_rsp_valid = shown;
    rsp_ready     = rsp_ready_nxt;
    for (int t = 0; t < NT; t++) begin
      tgt_rsp[t] = pend[t][0];
    end
  end

  initial begin
    logic [83:0] p;
    int          start;
    int          asrt_fails;
    for (int k = 0; k < MAX_PAT; k++) begin
      pat[k] = '1; // all ones marks the end of the list.
    end
    $readmemh("verification/icb_bus_patterns.hex", pat);
    while (n_pat < MAX_PAT && pat[n_pat] != '1) n_pat++;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < n_pat; i++) begin
      p = pat[i];
      if (p[11:4] != tgt_en) begin
        cmd_valid = 1'b0;
        while (rsp_cnt != acc_cnt) @(negedge clk); // drain before the map changes.
        tgt_en = p[11:4];
      end
      cur_tgt   = p[3:0];
      cmd.op    = icb_bus_pkg::icb_op_e'(p[80]);
      cmd.addr  = p[79:48];
      cmd.wdata = p[47:16];
      cmd.wmask = p[15:12];
      cmd_valid = 1'b1;
      start     = acc_cnt;
      while (acc_cnt == start) @(negedge clk);
    end
    cmd_valid = 1'b0;
    while (rsp_cnt != n_pat) @(negedge clk);
    repeat (2) @(negedge clk);
    asrt_fails = dut_i.u_splitter.u_props.fail_cnt;
    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             chk_cnt, err_cnt, asrt_fails);
    if (err_cnt == 0 && asrt_fails == 0 && n_pat > 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #1;
    repeat (n_pat * 64) @(posedge clk);
    $display("Timeout: only %0d of %0d responses came back.", rsp_cnt, n_pat);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/icb_bus_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module icb_bus_props (
  input wire                             clk,
  input wire                             i_rst_n,
  input wire                             i_cmd_valid,
  input wire                             o_cmd_ready,
  input icb_bus_pkg::icb_cmd_t           i_cmd,
  input wire                             o_rsp_valid,
  input wire                             i_rsp_ready,
  input icb_bus_pkg::icb_rsp_t           o_rsp,
  input wire [icb_bus_pkg::TGT_NUM-1:0]  o_tgt_cmd_valid
);

  int fail_cnt = 0;
  int outs_seen;

  // outstanding commands as counted from the handshakes on both links.
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      outs_seen <= 0;
    end else begin
      outs_seen <= outs_seen + int'(i_cmd_valid && o_cmd_ready)
                 - int'(o_rsp_valid && i_rsp_ready);
    end
  end

  // a stalled command keeps its valid and payload.
  cmd_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_cmd_valid && !o_cmd_ready |=> i_cmd_valid && $stable(i_cmd))
    else begin
      fail_cnt++;
      $error("stalled command changed before its transfer");
    end

  rsp_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp))
    else begin
      fail_cnt++;
      $error("stalled response changed before its transfer");
    end

  tgt_onehot: assert property (@(posedge clk) disable iff (!i_rst_n)
    $onehot0(o_tgt_cmd_valid))
    else begin
      fail_cnt++;
      $error("more than one target command valid is high");
    end

  // no new command may leave while the outstanding limit is reached.
  outs_limit: assert property (@(posedge clk) disable iff (!i_rst_n)
    outs_seen == icb_bus_pkg::OUTS_MAX |-> o_tgt_cmd_valid == '0)
    else begin
      fail_cnt++;
      $error("target command valid while outstanding count is at its limit");
    end

endmodule

bind icb_splitter icb_bus_props u_props (
  .clk             (clk),
  .i_rst_n         (i_rst_n),
  .i_cmd_valid     (i_cmd_valid),
  .o_cmd_ready     (o_cmd_ready),
  .i_cmd           (i_cmd),
  .o_rsp_valid     (o_rsp_valid),
  .i_rsp_ready     (i_rsp_ready),
  .o_rsp           (o_rsp),
  .o_tgt_cmd_valid (o_tgt_cmd_valid)
);

`default_nettype wire

// ==== src/icb_bus_1to8.sv ====
`timescale 1ns/1ps
`default_nettype none

module icb_bus_1to8 (
  input  wire                              clk,
  input  wire                              i_rst_n,
  input  wire  [icb_bus_pkg::TGT_NUM-1:0]  i_tgt_en,
  input  wire                              i_cmd_valid,
  output logic                             o_cmd_ready,
  input  icb_bus_pkg::icb_cmd_t            i_cmd,
  output logic                             o_rsp_valid,
  input  wire                              i_rsp_ready,
  output icb_bus_pkg::icb_rsp_t            o_rsp,
  output logic [icb_bus_pkg::TGT_NUM-1:0]  o_tgt_cmd_valid,
  input  wire  [icb_bus_pkg::TGT_NUM-1:0]  i_tgt_cmd_ready,
  output icb_bus_pkg::icb_cmd_t            o_tgt_cmd [icb_bus_pkg::TGT_NUM],
  input  wire  [icb_bus_pkg::TGT_NUM-1:0]  i_tgt_rsp_valid,
  output logic [icb_bus_pkg::TGT_NUM-1:0]  o_tgt_rsp_ready,
  input  icb_bus_pkg::icb_rsp_t            i_tgt_rsp [icb_bus_pkg::TGT_NUM]
);

  logic                          buf_cmd_valid;
  logic                          buf_cmd_ready;
  icb_bus_pkg::icb_cmd_t         buf_cmd;
  logic [icb_bus_pkg::SEL_W-1:0] buf_sel;

  icb_cmd_buffer u_cmd_buffer (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_cmd_valid (i_cmd_valid),
    .o_cmd_ready (o_cmd_ready),
    .i_cmd       (i_cmd),
    .o_cmd_valid (buf_cmd_valid),
    .i_cmd_ready (buf_cmd_ready),
    .o_cmd       (buf_cmd)
  );

  // decode works on the buffered command.
  icb_addr_decode u_addr_decode (
    .i_addr   (buf_cmd.addr),
    .i_tgt_en (i_tgt_en),
    .o_sel    (buf_sel)
  );

  icb_splitter u_splitter (
    .clk             (clk),
    .i_rst_n         (i_rst_n),
    .i_sel           (buf_sel),
    .i_cmd_valid     (buf_cmd_valid),
    .o_cmd_ready     (buf_cmd_ready),
    .i_cmd           (buf_cmd),
    .o_rsp_valid     (o_rsp_valid),
    .i_rsp_ready     (i_rsp_ready),
    .o_rsp           (o_rsp),
    .o_tgt_cmd_valid (o_tgt_cmd_valid),
    .i_tgt_cmd_ready (i_tgt_cmd_ready),
    .o_tgt_cmd       (o_tgt_cmd),
    .i_tgt_rsp_valid (i_tgt_rsp_valid),
    .o_tgt_rsp_ready (o_tgt_rsp_ready),
    .i_tgt_rsp       (i_tgt_rsp)
  );

endmodule

`default_nettype wire

// ==== src/icb_splitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module icb_splitter (
  input  wire                              clk,
  input  wire                              i_rst_n,
  input  wire [icb_bus_pkg::SEL_W-1:0]     i_sel,
  input  wire                              i_cmd_valid,
  output logic                             o_cmd_ready,
  input  icb_bus_pkg::icb_cmd_t            i_cmd,
  output logic                             o_rsp_valid,
  input  wire                              i_rsp_ready,
  output icb_bus_pkg::icb_rsp_t            o_rsp,
  output logic [icb_bus_pkg::TGT_NUM-1:0]  o_tgt_cmd_valid,
  input  wire  [icb_bus_pkg::TGT_NUM-1:0]  i_tgt_cmd_ready,
  output icb_bus_pkg::icb_cmd_t            o_tgt_cmd [icb_bus_pkg::TGT_NUM],
  input  wire  [icb_bus_pkg::TGT_NUM-1:0]  i_tgt_rsp_valid,
  output logic [icb_bus_pkg::TGT_NUM-1:0]  o_tgt_rsp_ready,
  input  icb_bus_pkg::icb_rsp_t            i_tgt_rsp [icb_bus_pkg::TGT_NUM]
);

  localparam int DEF = icb_bus_pkg::SEL_W - 1;

  icb_bus_pkg::outs_cnt_t        outs_cnt_q;
  logic [icb_bus_pkg::SEL_W-1:0] sel_q;
  logic                          outs_busy;
  logic                          cmd_stall;
  logic                          cmd_hsk;
  logic                          rsp_hsk;
  logic                          tgt_rsp_vld;
  icb_bus_pkg::icb_rsp_t         tgt_rsp_mux;
  icb_bus_pkg::icb_rsp_t         def_rsp;

  assign outs_busy = (outs_cnt_q != '0);

  // a new command waits while the limit is reached or a different target is in flight.
  assign cmd_stall = (outs_cnt_q == icb_bus_pkg::outs_cnt_t'(icb_bus_pkg::OUTS_MAX))
                   | (outs_busy & (i_sel != sel_q));

  // the default slot takes commands at once.
  assign o_cmd_ready = ~cmd_stall
                     & (i_sel[DEF] | (|(i_sel[icb_bus_pkg::TGT_NUM-1:0] & i_tgt_cmd_ready)));

  assign o_tgt_cmd_valid = {icb_bus_pkg::TGT_NUM{i_cmd_valid & ~cmd_stall}}
                         & i_sel[icb_bus_pkg::TGT_NUM-1:0];

  for (genvar g = 0; g < icb_bus_pkg::TGT_NUM; g++) begin : g_tgt
    assign o_tgt_cmd[g] = i_cmd;
    assign o_tgt_rsp_ready[g] = outs_busy & sel_q[g] & i_rsp_ready;
  end

  assign cmd_hsk = i_cmd_valid & o_cmd_ready;
  assign rsp_hsk = o_rsp_valid & i_rsp_ready;

  always_comb begin
    tgt_rsp_vld = 1'b0;
    tgt_rsp_mux = '0;
    for (int i = 0; i < icb_bus_pkg::TGT_NUM; i++) begin
      if (sel_q[i]) begin
        tgt_rsp_vld = i_tgt_rsp_valid[i];
        tgt_rsp_mux = i_tgt_rsp[i];
      end
    end
  end

  // unmapped commands get an error with zero data.
  assign def_rsp.err   = 1'b1;
  assign def_rsp.rdata = '0;

  assign o_rsp_valid = outs_busy & (sel_q[DEF] | tgt_rsp_vld);
  assign o_rsp       = sel_q[DEF] ? def_rsp : tgt_rsp_mux;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      outs_cnt_q <= '0;
      sel_q      <= '0;
    end else begin
      if (cmd_hsk && !rsp_hsk) begin
        outs_cnt_q <= outs_cnt_q + icb_bus_pkg::outs_cnt_t'(1);
      end else if (rsp_hsk && !cmd_hsk) begin
        outs_cnt_q <= outs_cnt_q - icb_bus_pkg::outs_cnt_t'(1);
      end
      if (cmd_hsk) sel_q <= i_sel; // unchanged while busy, since the select must match.
    end
  end

endmodule

`default_nettype wire

// ==== src/icb_addr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module icb_addr_decode (
  input  wire [icb_bus_pkg::ADDR_W-1:0]  i_addr,
  input  wire [icb_bus_pkg::TGT_NUM-1:0] i_tgt_en,
  output logic [icb_bus_pkg::SEL_W-1:0]  o_sel
);

  logic [icb_bus_pkg::TGT_NUM-1:0] hit;

  for (genvar g = 0; g < icb_bus_pkg::TGT_NUM; g++) begin : g_region
    // bits below the region lsb are masked off before the compare.
    assign hit[g] = i_tgt_en[g]
                  & (((i_addr ^ icb_bus_pkg::TGT_BASE[g])
                     & ({icb_bus_pkg::ADDR_W{1'b1}} << icb_bus_pkg::TGT_REGION_LSB[g]))
                     == '0);
  end

  // regions never overlap, so at most one hit is set.
  assign o_sel = {~|hit, hit};

endmodule

`default_nettype wire

// ==== src/icb_cmd_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module icb_cmd_buffer (
  input  wire                   clk,
  input  wire                   i_rst_n,
  input  wire                   i_cmd_valid,
  output logic                  o_cmd_ready,
  input  icb_bus_pkg::icb_cmd_t i_cmd,
  output logic                  o_cmd_valid,
  input  wire                   i_cmd_ready,
  output icb_bus_pkg::icb_cmd_t o_cmd
);

  icb_bus_pkg::icb_cmd_t mem [2];
  logic                  wr_ptr_q;
  logic                  rd_ptr_q;
  logic [1:0]            cnt_q;
  logic [1:0]            cnt_nxt;
  logic                  full_q;
  logic                  push;
  logic                  pop;

  assign push = i_cmd_valid & o_cmd_ready;
  assign pop  = o_cmd_valid & i_cmd_ready;

  assign o_cmd_ready = ~full_q; // no combinational path from i_cmd_ready.
  assign o_cmd_valid = (cnt_q != 2'd0);
  assign o_cmd       = mem[rd_ptr_q];

  always_comb begin
    cnt_nxt = cnt_q;
    if (push && !pop) begin
      cnt_nxt = cnt_q + 2'd1;
    end else if (pop && !push) begin
      cnt_nxt = cnt_q - 2'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
      full_q   <= 1'b0;
    end else begin
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop)  rd_ptr_q <= ~rd_ptr_q;
      cnt_q  <= cnt_nxt;
      full_q <= (cnt_nxt == 2'd2);
    end
  end

  // storage is written only on a push, so it needs no reset.
  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr_q] <= i_cmd;
  end

endmodule

`default_nettype wire

// ==== src/icb_bus_pkg.sv ====
`default_nettype none

package icb_bus_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int MASK_W = DATA_W / 8;

  localparam int TGT_NUM = 8;
  localparam int SEL_W   = TGT_NUM + 1; // top bit is the default slot.

  // targets 0 to 6 take 4 KiB each, target 7 takes a 64 KiB window.
  localparam logic [ADDR_W-1:0] TGT_BASE [TGT_NUM] = '{
    32'h1000_0000,
    32'h1000_1000,
    32'h1000_2000,
    32'h1000_3000,
    32'h1000_4000,
    32'h1000_5000,
    32'h1000_6000,
    32'h2000_0000
  };

  localparam int TGT_REGION_LSB [TGT_NUM] = '{12, 12, 12, 12, 12, 12, 12, 16};

  localparam int OUTS_MAX = 2;
  localparam int OUTS_W   = $clog2(OUTS_MAX + 1);

  typedef logic [OUTS_W-1:0] outs_cnt_t;

  typedef enum logic {
    ICB_WRITE = 1'b0,
    ICB_READ  = 1'b1
  } icb_op_e;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    icb_op_e           op;
    logic [DATA_W-1:0] wdata;
    logic [MASK_W-1:0] wmask;
  } icb_cmd_t;

  typedef struct packed {
    logic              err;
    logic [DATA_W-1:0] rdata;
  } icb_rsp_t;

endpackage

`default_nettype wire
